// ==== Makefile ====
# verilator flow for the packet filter

SIM = obj_dir/filter_sim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module filter_top -f vlog.f

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module filter_tb -f vlog.f -o filter_sim
	out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// ==== logic/action_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_stage (
	input  wire                                       clk,
	input  wire                                       aresetn,

	// data stream from the filter
	input  wire [filter_pkg::data_width-1:0]          d_tdata,
	input  wire [filter_pkg::keep_width-1:0]          d_tkeep,
	input  wire [filter_pkg::tuser_width-1:0]         d_tuser,
	input  wire                                       d_tvalid,
	input  wire                                       d_tlast,
	output logic                                      d_tready,

	// table writes from the control path
	input  wire                                       tbl_wr_en,
	input  wire [filter_pkg::table_addr_width-1:0]    tbl_wr_addr,
	input  wire [filter_pkg::port_width-1:0]          tbl_wr_port,
	input  wire                                       tbl_wr_valid,

	// egress stream
	output logic [filter_pkg::data_width-1:0]         m_axis_tdata,
	output logic [filter_pkg::keep_width-1:0]         m_axis_tkeep,
	output logic [filter_pkg::tuser_width-1:0]        m_axis_tuser,
	output logic                                      m_axis_tvalid,
	output logic                                      m_axis_tlast,
	input  wire                                       m_axis_tready
);

	// action table, enable plus output port per entry
	logic                               tbl_en   [filter_pkg::table_depth];
	logic [filter_pkg::port_width-1:0]  tbl_port [filter_pkg::table_depth];

	logic                                     first;
	logic                                     d_beat;
	logic                                     adv;
	logic                                     hit;
	logic [filter_pkg::table_addr_width-1:0]  lkp_idx;
	logic [filter_pkg::tuser_width-1:0]       tuser_next;

	// ready follows the sink, same rule as the filter
	assign d_tready = m_axis_tready;
	assign d_beat   = d_tvalid && d_tready;
	assign adv      = !m_axis_tvalid || m_axis_tready;

	// low bits of the flow tag select the entry
	assign lkp_idx = d_tdata[filter_pkg::flow_tag_lsb +: filter_pkg::table_addr_width];
	// only the first beat carries the header
	assign hit     = first && tbl_en[lkp_idx];

	always_comb begin
		tuser_next = d_tuser;
		if (hit) begin
			tuser_next[filter_pkg::tuser_dst_lsb +: filter_pkg::port_width] = tbl_port[lkp_idx];
		end
	end

	// table writes, seen by lookups on the next cycle
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < filter_pkg::table_depth; i++) begin
				tbl_en[i]   <= 1'b0;
				tbl_port[i] <= '0;
			end
		end else if (tbl_wr_en) begin
			tbl_en[tbl_wr_addr]   <= tbl_wr_valid;
			tbl_port[tbl_wr_addr] <= tbl_wr_port;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			first         <= 1'b1;
			m_axis_tvalid <= 1'b0;
		end else begin
			// frame boundary tracking on accepted beats
			if (d_beat) begin
				first <= d_tlast;
			end
			if (adv) begin
				m_axis_tvalid <= d_beat;
			end
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (d_beat) begin
			m_axis_tdata <= d_tdata;
			m_axis_tkeep <= d_tkeep;
			m_axis_tuser <= tuser_next;
			m_axis_tlast <= d_tlast;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ctrl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
	input  wire                                       clk,
	input  wire                                       aresetn,

	// control stream from the filter
	input  wire [filter_pkg::data_width-1:0]          c_tdata,
	input  wire                                       c_tvalid,
	input  wire                                       c_tlast,

	// table write port
	output logic                                      tbl_wr_en,
	output logic [filter_pkg::table_addr_width-1:0]   tbl_wr_addr,
	output logic [filter_pkg::port_width-1:0]         tbl_wr_port,
	output logic                                      tbl_wr_valid
);

	// high while the next control beat opens a frame
	logic first;
	logic first_beat;

	assign first_beat = c_tvalid && first;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			first     <= 1'b1;
			tbl_wr_en <= 1'b0;
		end else begin
			if (c_tvalid) begin
				first <= c_tlast;
			end
			// one pulse per control frame
			tbl_wr_en <= first_beat;
		end
	end

	// write fields come from the first beat only
	always_ff @(posedge clk) begin
		if (first_beat) begin
			tbl_wr_addr  <= c_tdata[filter_pkg::ctrl_index_lsb +: filter_pkg::table_addr_width];
			tbl_wr_port  <= c_tdata[filter_pkg::ctrl_value_lsb +: filter_pkg::port_width];
			// bit 0 of the enable byte
			tbl_wr_valid <= c_tdata[filter_pkg::ctrl_enable_lsb];
		end
	end

endmodule

`default_nettype wire

// ==== logic/filter_pkg.sv ====
`default_nettype none

package filter_pkg;

	// stream widths
	localparam int unsigned data_width  = 512;
	localparam int unsigned keep_width  = 64;
	localparam int unsigned tuser_width = 128;

	// ethertype sits byte-swapped in tdata
	localparam int unsigned eth_type_lsb  = 128;
	localparam logic [15:0] eth_type_ipv4 = 16'h0008;

	// ip protocol byte
	localparam int unsigned ip_proto_lsb = 216;
	localparam logic [7:0]  ip_proto_udp = 8'h11;

	// udp port that marks a control frame
	localparam int unsigned ctrl_port_lsb = 320;
	localparam logic [15:0] ctrl_port     = 16'hf2f1;

	// flow tag byte in a data frame, low bits pick the table entry
	localparam int unsigned flow_tag_lsb = 368;

	// control frame layout, enable is bit 0 of its byte
	localparam int unsigned ctrl_index_lsb  = 368;
	localparam int unsigned ctrl_value_lsb  = 376;
	localparam int unsigned ctrl_enable_lsb = 384;

	// action table
	localparam int unsigned table_depth      = 16;
	localparam int unsigned table_addr_width = 4;

	// output port byte inside tuser
	localparam int unsigned tuser_dst_lsb = 24;
	localparam int unsigned port_width    = 8;

endpackage

`default_nettype wire

// ==== logic/filter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module filter_top (
	input  wire                                  clk,
	input  wire                                  aresetn,

	// ingress
	input  wire [filter_pkg::data_width-1:0]     s_axis_tdata,
	input  wire [filter_pkg::keep_width-1:0]     s_axis_tkeep,
	input  wire [filter_pkg::tuser_width-1:0]    s_axis_tuser,
	input  wire                                  s_axis_tvalid,
	input  wire                                  s_axis_tlast,
	output wire                                  s_axis_tready,

	// egress
	output wire [filter_pkg::data_width-1:0]     m_axis_tdata,
	output wire [filter_pkg::keep_width-1:0]     m_axis_tkeep,
	output wire [filter_pkg::tuser_width-1:0]    m_axis_tuser,
	output wire                                  m_axis_tvalid,
	output wire                                  m_axis_tlast,
	input  wire                                  m_axis_tready
);

	// filter to action stage
	wire [filter_pkg::data_width-1:0]   d_tdata;
	wire [filter_pkg::keep_width-1:0]   d_tkeep;
	wire [filter_pkg::tuser_width-1:0]  d_tuser;
	wire                                d_tvalid;
	wire                                d_tlast;
	wire                                d_tready;

	// filter to decoder
	wire [filter_pkg::data_width-1:0]   c_tdata;
	wire                                c_tvalid;
	wire                                c_tlast;

	// decoder to action table
	wire                                      tbl_wr_en;
	wire [filter_pkg::table_addr_width-1:0]   tbl_wr_addr;
	wire [filter_pkg::port_width-1:0]         tbl_wr_port;
	wire                                      tbl_wr_valid;

	pkt_filter pkt_filter_inst (
		.clk           (clk),
		.aresetn       (aresetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tkeep  (s_axis_tkeep),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.d_tdata       (d_tdata),
		.d_tkeep       (d_tkeep),
		.d_tuser       (d_tuser),
		.d_tvalid      (d_tvalid),
		.d_tlast       (d_tlast),
		.d_tready      (d_tready),
		.c_tdata       (c_tdata),
		.c_tvalid      (c_tvalid),
		.c_tlast       (c_tlast)
	);

	ctrl_decoder ctrl_decoder_inst (
		.clk          (clk),
		.aresetn      (aresetn),
		.c_tdata      (c_tdata),
		.c_tvalid     (c_tvalid),
		.c_tlast      (c_tlast),
		.tbl_wr_en    (tbl_wr_en),
		.tbl_wr_addr  (tbl_wr_addr),
		.tbl_wr_port  (tbl_wr_port),
		.tbl_wr_valid (tbl_wr_valid)
	);

	action_stage action_stage_inst (
		.clk           (clk),
		.aresetn       (aresetn),
		.d_tdata       (d_tdata),
		.d_tkeep       (d_tkeep),
		.d_tuser       (d_tuser),
		.d_tvalid      (d_tvalid),
		.d_tlast       (d_tlast),
		.d_tready      (d_tready),
		.tbl_wr_en     (tbl_wr_en),
		.tbl_wr_addr   (tbl_wr_addr),
		.tbl_wr_port   (tbl_wr_port),
		.tbl_wr_valid  (tbl_wr_valid),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

endmodule

`default_nettype wire

// ==== logic/pkt_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_filter (
	input  wire                                  clk,
	input  wire                                  aresetn,

	// ingress stream
	input  wire [filter_pkg::data_width-1:0]     s_axis_tdata,
	input  wire [filter_pkg::keep_width-1:0]     s_axis_tkeep,
	input  wire [filter_pkg::tuser_width-1:0]    s_axis_tuser,
	input  wire                                  s_axis_tvalid,
	input  wire                                  s_axis_tlast,
	output logic                                 s_axis_tready,

	// data path towards the action stage
	output logic [filter_pkg::data_width-1:0]    d_tdata,
	output logic [filter_pkg::keep_width-1:0]    d_tkeep,
	output logic [filter_pkg::tuser_width-1:0]   d_tuser,
	output logic                                 d_tvalid,
	output logic                                 d_tlast,
	input  wire                                  d_tready,

	// control path, no ready
	output logic [filter_pkg::data_width-1:0]    c_tdata,
	output logic                                 c_tvalid,
	output logic                                 c_tlast
);

	typedef enum logic [1:0] {
		wait_first,
		flush_data,
		flush_ctl,
		drop
	} state_t;

	state_t state;
	state_t state_next;

	logic beat_in;
	logic adv;
	logic is_ip_udp;
	logic is_ctrl;
	logic route_data;
	logic route_ctrl;

	// shared payload register for both outputs
	logic [filter_pkg::data_width-1:0] out_tdata;
	logic                              out_tlast;

	// a stalled data path stalls control frames too
	assign s_axis_tready = d_tready;
	assign beat_in       = s_axis_tvalid && s_axis_tready;
	// output register moves when empty or being drained
	assign adv           = !d_tvalid || d_tready;

	// first beat header checks
	assign is_ip_udp =
		(s_axis_tdata[filter_pkg::eth_type_lsb +: $bits(filter_pkg::eth_type_ipv4)]
			== filter_pkg::eth_type_ipv4) &&
		(s_axis_tdata[filter_pkg::ip_proto_lsb +: $bits(filter_pkg::ip_proto_udp)]
			== filter_pkg::ip_proto_udp);
	assign is_ctrl = is_ip_udp &&
		(s_axis_tdata[filter_pkg::ctrl_port_lsb +: $bits(filter_pkg::ctrl_port)]
			== filter_pkg::ctrl_port);

	always_comb begin
		state_next = state;
		route_data = 1'b0;
		route_ctrl = 1'b0;
		case (state)
			wait_first: begin
				// classify on the beat itself
				route_data = is_ip_udp && !is_ctrl;
				route_ctrl = is_ctrl;
				// single-beat frames stay here
				if (beat_in && !s_axis_tlast) begin
					if (is_ctrl) begin
						state_next = flush_ctl;
					end else if (is_ip_udp) begin
						state_next = flush_data;
					end else begin
						state_next = drop;
					end
				end
			end
			flush_data: begin
				route_data = 1'b1;
				if (beat_in && s_axis_tlast) begin
					state_next = wait_first;
				end
			end
			flush_ctl: begin
				route_ctrl = 1'b1;
				if (beat_in && s_axis_tlast) begin
					state_next = wait_first;
				end
			end
			default: begin
				// drop, both valids stay low
				if (beat_in && s_axis_tlast) begin
					state_next = wait_first;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state    <= wait_first;
			d_tvalid <= 1'b0;
			c_tvalid <= 1'b0;
		end else begin
			state <= state_next;
			if (adv) begin
				d_tvalid <= beat_in && route_data;
			end
			// control beats never wait
			c_tvalid <= beat_in && route_ctrl;
		end
	end

	// payload only moves with an accepted beat
	always_ff @(posedge clk) begin
		if (beat_in) begin
			out_tdata <= s_axis_tdata;
			d_tkeep   <= s_axis_tkeep;
			d_tuser   <= s_axis_tuser;
			out_tlast <= s_axis_tlast;
		end
	end

	assign d_tdata = out_tdata;
	assign d_tlast = out_tlast;
	assign c_tdata = out_tdata;
	assign c_tlast = out_tlast;

endmodule

`default_nettype wire

// ==== testbench/filter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module filter_tb;

	typedef logic [filter_pkg::data_width-1:0] wide_t;
	typedef enum {frame_data, frame_ctrl, frame_arp, frame_tcp} frame_kind_t;

	localparam int timeout_cycles = 400;

	logic                                clk = 1'b0;
	logic                                aresetn;
	logic [filter_pkg::data_width-1:0]   s_axis_tdata;
	logic [filter_pkg::keep_width-1:0]   s_axis_tkeep;
	logic [filter_pkg::tuser_width-1:0]  s_axis_tuser;
	logic                                s_axis_tvalid;
	logic                                s_axis_tlast;
	wire                                 s_axis_tready;
	wire  [filter_pkg::data_width-1:0]   m_axis_tdata;
	wire  [filter_pkg::keep_width-1:0]   m_axis_tkeep;
	wire  [filter_pkg::tuser_width-1:0]  m_axis_tuser;
	wire                                 m_axis_tvalid;
	wire                                 m_axis_tlast;
	logic                                m_axis_tready;

	// sink either follows a fixed level or stalls at random
	logic toggle_ready;
	logic sink_level;

	// expected egress beats, oldest first
	logic [filter_pkg::data_width-1:0]   exp_data [$];
	logic [filter_pkg::keep_width-1:0]   exp_keep [$];
	logic [filter_pkg::tuser_width-1:0]  exp_user [$];
	logic                                exp_last [$];

	// reference copy of the action table
	logic                                model_en   [filter_pkg::table_depth];
	logic [filter_pkg::port_width-1:0]   model_port [filter_pkg::table_depth];

	// beats of the frame being sent
	logic [filter_pkg::data_width-1:0]   frm_data [$];
	logic [filter_pkg::keep_width-1:0]   frm_keep [$];
	logic [filter_pkg::tuser_width-1:0]  frm_user [$];

	filter_top filter_top_inst (
		.clk           (clk),
		.aresetn       (aresetn),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tkeep  (s_axis_tkeep),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tready (m_axis_tready)
	);

	always #4 clk = ~clk;

	// sink ready changes just after the rising edge
	always @(posedge clk) begin
		#1;
		if (toggle_ready) begin
			m_axis_tready = ($urandom % 3) != 0;
		end else begin
			m_axis_tready = sink_level;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input wide_t expected, input wide_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAIL %0t %s expected %0h actual %0h",
				$time, name, expected, actual));
		end
	endtask

	function automatic wide_t random_bits();
		wide_t r;
		for (int i = 0; i < filter_pkg::data_width / 32; i++) begin
			r[i*32 +: 32] = $urandom;
		end
		return r;
	endfunction

	// egress monitor, outputs are stable at the falling edge
	always @(negedge clk) begin
		if (aresetn === 1'b1 && m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
			if (exp_data.size() == 0) begin
				abort_run("an output beat came out when none was expected");
			end else begin
				check("m_axis_tdata", exp_data.pop_front(), m_axis_tdata);
				check("m_axis_tkeep", wide_t'(exp_keep.pop_front()), wide_t'(m_axis_tkeep));
				check("m_axis_tuser", wide_t'(exp_user.pop_front()), wide_t'(m_axis_tuser));
				check("m_axis_tlast", wide_t'(exp_last.pop_front()), wide_t'(m_axis_tlast));
			end
		end
	end

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge clk);
		#1;
	endtask

	// f0 is the flow tag or table index, f1 the port value, f2 the enable byte
	task automatic send_frame(input frame_kind_t kind, input int nbeats,
		input logic [7:0] f0, input logic [7:0] f1, input logic [7:0] f2);
		wide_t                                    beat;
		wide_t                                    extra;
		logic [filter_pkg::keep_width-1:0]        keep;
		logic [filter_pkg::tuser_width-1:0]       user;
		logic [filter_pkg::table_addr_width-1:0]  idx;
		int                                       waited;
		logic                                     taken;
		frm_data.delete();
		frm_keep.delete();
		frm_user.delete();
		for (int i = 0; i < nbeats; i++) begin
			beat  = random_bits();
			extra = random_bits();
			user  = extra[filter_pkg::tuser_width-1:0];
			keep  = '1;
			// last beat may be partial, at least one byte kept
			if (i == nbeats - 1) begin
				keep = keep >> extra[filter_pkg::tuser_width +: 6];
			end
			if (i == 0) begin
				beat[filter_pkg::eth_type_lsb +: 16] =
					(kind == frame_arp) ? 16'h0608 : filter_pkg::eth_type_ipv4;
				beat[filter_pkg::ip_proto_lsb +: 8] =
					(kind == frame_tcp) ? 8'h06 : filter_pkg::ip_proto_udp;
				beat[filter_pkg::ctrl_port_lsb +: 16] =
					(kind == frame_ctrl) ? filter_pkg::ctrl_port : filter_pkg::ctrl_port ^ 16'h0400;
				if (kind == frame_ctrl) begin
					beat[filter_pkg::ctrl_index_lsb +: 8]  = f0;
					beat[filter_pkg::ctrl_value_lsb +: 8]  = f1;
					beat[filter_pkg::ctrl_enable_lsb +: 8] = f2;
				end else begin
					beat[filter_pkg::flow_tag_lsb +: 8] = f0;
				end
			end else if (kind == frame_ctrl) begin
				// later control beats carry a conflicting write that must be ignored
				beat[filter_pkg::ctrl_index_lsb +: 8]  = f0;
				beat[filter_pkg::ctrl_value_lsb +: 8]  = ~f1;
				beat[filter_pkg::ctrl_enable_lsb +: 8] = ~f2;
			end else begin
				// same tag again, a lookup on this beat would hit
				beat[filter_pkg::flow_tag_lsb +: 8] = f0;
			end
			frm_data.push_back(beat);
			frm_keep.push_back(keep);
			frm_user.push_back(user);
		end

		// data frames come out, first beat port rewritten on a table hit
		if (kind == frame_data) begin
			idx = f0[filter_pkg::table_addr_width-1:0];
			for (int i = 0; i < nbeats; i++) begin
				user = frm_user[i];
				if (i == 0 && model_en[idx]) begin
					user[filter_pkg::tuser_dst_lsb +: filter_pkg::port_width] = model_port[idx];
				end
				exp_data.push_back(frm_data[i]);
				exp_keep.push_back(frm_keep[i]);
				exp_user.push_back(user);
				exp_last.push_back(i == nbeats - 1);
			end
		end
		if (kind == frame_ctrl) begin
			idx = f0[filter_pkg::table_addr_width-1:0];
			model_en[idx]   = f2[0];
			model_port[idx] = f1;
		end

		for (int i = 0; i < nbeats; i++) begin
			s_axis_tdata  = frm_data[i];
			s_axis_tkeep  = frm_keep[i];
			s_axis_tuser  = frm_user[i];
			s_axis_tlast  = (i == nbeats - 1);
			s_axis_tvalid = 1'b1;
			waited = 0;
			taken  = 1'b0;
			// beat moves on the next rising edge if ready is high mid-cycle
			while (!taken) begin
				@(negedge clk);
				taken = s_axis_tready;
				@(posedge clk);
				#1;
				waited++;
				if (!taken && waited > timeout_cycles) begin
					abort_run("timeout waiting for s_axis_tready during a frame");
				end
			end
		end
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		// let the table write land before the next lookup
		if (kind == frame_ctrl) begin
			idle(4);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > timeout_cycles) begin
				abort_run("timeout, expected output beats never came out");
			end
		end
		// quiet period catches stray or repeated beats
		repeat (8) @(posedge clk);
		#1;
	endtask

	task automatic reset_outputs_low();
		@(negedge clk);
		check("m_axis_tvalid", '0, wide_t'(m_axis_tvalid));
		check("s_axis_tready", '0, wide_t'(s_axis_tready));
		sink_level = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check("m_axis_tvalid", '0, wide_t'(m_axis_tvalid));
		check("s_axis_tready", wide_t'(1'b1), wide_t'(s_axis_tready));
		@(posedge clk);
		#1;
	endtask

	task automatic data_frames_unchanged();
		send_frame(frame_data, 1, 8'h13, 8'h00, 8'h00);
		send_frame(frame_data, 3, 8'h47, 8'h00, 8'h00);
		wait_drain();
	endtask

	task automatic foreign_frames_dropped();
		send_frame(frame_arp, 2, 8'h05, 8'h00, 8'h00);
		send_frame(frame_tcp, 1, 8'h05, 8'h00, 8'h00);
		send_frame(frame_data, 2, 8'h21, 8'h00, 8'h00);
		wait_drain();
	endtask

	task automatic table_rewrites_port();
		// index byte high bits are ignored, entry 5
		send_frame(frame_ctrl, 2, 8'h35, 8'h3c, 8'h01);
		wait_drain();
		send_frame(frame_data, 3, 8'h25, 8'h00, 8'h00);
		send_frame(frame_data, 1, 8'h06, 8'h00, 8'h00);
		wait_drain();
		// enable bit clear, other bits of the byte set
		send_frame(frame_ctrl, 1, 8'h05, 8'h77, 8'hfe);
		send_frame(frame_data, 2, 8'h05, 8'h00, 8'h00);
		wait_drain();
	endtask

	task automatic random_sink_stalls();
		int pick;
		toggle_ready = 1'b1;
		for (int n = 0; n < 20; n++) begin
			pick = $urandom % 8;
			case (pick)
				0, 1, 2, 3: send_frame(frame_data, 1 + ($urandom % 4), 8'($urandom % 4),
					8'h00, 8'h00);
				4, 5: send_frame(frame_ctrl, 1 + ($urandom % 2), 8'($urandom % 4),
					8'($urandom), 8'($urandom));
				6: send_frame(frame_arp, 1 + ($urandom % 3), 8'h00, 8'h00, 8'h00);
				default: send_frame(frame_tcp, 1 + ($urandom % 3), 8'h00, 8'h00, 8'h00);
			endcase
		end
		wait_drain();
		toggle_ready = 1'b0;
		idle(2);
	endtask

	initial begin
		void'($urandom(32'h2b3b_34f3));
		$timeformat(-9, 0, " ns", 0);
		aresetn       = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tkeep  = '0;
		s_axis_tuser  = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast  = 1'b0;
		m_axis_tready = 1'b0;
		toggle_ready  = 1'b0;
		sink_level    = 1'b0;
		for (int i = 0; i < filter_pkg::table_depth; i++) begin
			model_en[i]   = 1'b0;
			model_port[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		aresetn = 1'b1;

		reset_outputs_low();
		data_frames_unchanged();
		foreign_frames_dropped();
		table_rewrites_port();
		random_sink_stalls();
		wait_drain();

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/filter_pkg.sv
logic/pkt_filter.sv
logic/ctrl_decoder.sv
logic/action_stage.sv
logic/filter_top.sv
testbench/filter_tb.sv
